/* logic/sdram_pkg.sv */
package sdram_pkg;

  // reduced geometry, small enough for a quick simulation
  localparam int BANK_W = 2;
  localparam int ROW_W  = 4;
  localparam int COL_W  = 5;

  localparam int DQ_W    = 16;
  localparam int HOST_DW = 32;

  // host word address is bank, row, column pair
  localparam int HOST_AW = BANK_W + ROW_W + COL_W - 1;

  localparam int A_W = 13;

  localparam int CAS_LAT = 2;

  // burst length code 1 selects two beats
  localparam logic [2:0] BL_CODE = 3'b001;

  localparam int MR_BL_LSB = 0;
  localparam int MR_CL_LSB = 4;

  typedef enum logic [2:0] {
    NOP,
    ACTIVE,
    READ,
    WRITE,
    LOAD_MODE,
    BURST_STOP
  } sdram_cmd_e;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_MODE,
    ST_IDLE,
    ST_ACTIVE,
    ST_WRITE,
    ST_WRITE_HI,
    ST_READ
  } ctrl_state_e;

endpackage

/* logic/sdram_write_path.sv */
`timescale 1ns/1ps

module sdram_write_path (
  input  logic                         clk,
  input  logic                         wr_cmd,
  input  logic                         burst_stop,
  input  logic [sdram_pkg::COL_W-1:0]  col,
  input  logic [3:0]                   burst_len,
  input  logic [sdram_pkg::DQ_W/8-1:0] dqm,
  input  logic [sdram_pkg::DQ_W-1:0]   dq_in,
  input  logic [sdram_pkg::DQ_W-1:0]   old_word,
  output logic                         mem_we,
  output logic [sdram_pkg::COL_W-1:0]  mem_col,
  output logic [sdram_pkg::DQ_W-1:0]   mem_wdata,
  output logic                         burst_active
);

  logic [sdram_pkg::COL_W-1:0] wr_col;
  logic [3:0]                  beat_cnt;

  assign burst_active = (beat_cnt != 4'd0);

  // first beat lands with the command, the rest follow from wr_col
  always_ff @(posedge clk) begin
    if (wr_cmd) begin
      wr_col   <= col + 1'b1;
      beat_cnt <= (burst_len > 4'd1) ? 4'd1 : 4'd0;
    end else if (burst_stop) begin
      beat_cnt <= 4'd0;
    end else if (burst_active) begin
      wr_col   <= wr_col + 1'b1;
      beat_cnt <= (beat_cnt + 4'd1 == burst_len) ? 4'd0 : beat_cnt + 4'd1;
    end
  end

  assign mem_we  = wr_cmd || (burst_active && !burst_stop);
  assign mem_col = wr_cmd ? col : wr_col;

  // masked bytes keep the stored value
  always_comb begin
    for (int i = 0; i < sdram_pkg::DQ_W/8; i++) begin
      mem_wdata[8*i +: 8] = dqm[i] ? old_word[8*i +: 8] : dq_in[8*i +: 8];
    end
  end

  a_beat_in_range: assert property (
    @(posedge clk) burst_active |-> (beat_cnt < burst_len)
  );

endmodule

/* logic/sdram_read_path.sv */
`timescale 1ns/1ps

module sdram_read_path (
  input  logic                        clk,
  input  logic                        rd_cmd,
  input  logic [sdram_pkg::COL_W-1:0] col,
  input  logic [2:0]                  cas_lat,
  input  logic [sdram_pkg::DQ_W-1:0]  mem_rdata,
  output logic [sdram_pkg::COL_W-1:0] mem_col,
  output logic [sdram_pkg::DQ_W-1:0]  rd_data
);

  logic [sdram_pkg::COL_W-1:0] rd_col;
  logic [sdram_pkg::DQ_W-1:0]  data_p;
  logic [sdram_pkg::DQ_W-1:0]  data_2p;

  // column runs freely after the command
  always_ff @(posedge clk) begin
    if (rd_cmd)
      rd_col <= col;
    else
      rd_col <= rd_col + 1'b1;
  end

  assign mem_col = rd_col;

  always_ff @(posedge clk) begin
    data_p  <= mem_rdata;
    data_2p <= data_p;
  end

  // one stage for CL2, two for CL3
  assign rd_data = (cas_lat == 3'd2) ? data_p : data_2p;

  // mode must be loaded with a supported latency before any read
  a_cas_lat_valid: assert property (
    @(posedge clk) rd_cmd |-> (cas_lat inside {3'd2, 3'd3})
  );

endmodule

/* logic/sdram_bank_array.sv */
`timescale 1ns/1ps

module sdram_bank_array (
  input  logic                         clk,
  input  logic [sdram_pkg::BANK_W-1:0] bank,
  input  logic [sdram_pkg::ROW_W-1:0]  row,
  input  logic                         we,
  input  logic [sdram_pkg::COL_W-1:0]  wcol,
  input  logic [sdram_pkg::DQ_W-1:0]   wdata,
  input  logic [sdram_pkg::COL_W-1:0]  rcol,
  output logic [sdram_pkg::DQ_W-1:0]   old_word,
  output logic [sdram_pkg::DQ_W-1:0]   rdata
);

  // all banks in one array
  logic [sdram_pkg::DQ_W-1:0] mem [2**sdram_pkg::BANK_W]
                                  [2**sdram_pkg::ROW_W]
                                  [2**sdram_pkg::COL_W];

  always_ff @(posedge clk) begin
    if (we)
      mem[bank][row][wcol] <= wdata;
  end

  // merge source for the write path
  assign old_word = mem[bank][row][wcol];

  assign rdata = mem[bank][row][rcol];

endmodule

/* logic/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model (
  input  logic                         clk,
  input  logic                         cs,
  input  logic                         ras,
  input  logic                         cas,
  input  logic                         we,
  input  logic [sdram_pkg::A_W-1:0]    a,
  input  logic [sdram_pkg::BANK_W-1:0] ba,
  input  logic [sdram_pkg::DQ_W/8-1:0] dqm,
  input  logic [sdram_pkg::DQ_W-1:0]   dq_in,
  output logic [sdram_pkg::DQ_W-1:0]   dq_out,
  output logic                         dq_oe
);

  sdram_pkg::sdram_cmd_e cmd;

  logic [sdram_pkg::A_W-1:0]    mode_reg;
  logic                         mode_loaded;
  logic [sdram_pkg::BANK_W-1:0] bank_q;
  logic [sdram_pkg::ROW_W-1:0]  row_q;
  logic [2:0]                   bl_code;
  logic [2:0]                   cas_lat;
  logic [3:0]                   burst_len;
  logic                         wr_cmd;
  logic                         rd_cmd;
  logic                         burst_stop;
  logic                         burst_active;
  logic                         mem_we;
  logic [sdram_pkg::COL_W-1:0]  wr_col;
  logic [sdram_pkg::COL_W-1:0]  rd_col;
  logic [sdram_pkg::DQ_W-1:0]   mem_wdata;
  logic [sdram_pkg::DQ_W-1:0]   old_word;
  logic [sdram_pkg::DQ_W-1:0]   mem_rdata;

  // cke held high, so only cs and the three strobes matter
  always_comb begin
    cmd = sdram_pkg::NOP;
    if (!cs) begin
      case ({ras, cas, we})
        3'b000:  cmd = sdram_pkg::LOAD_MODE;
        3'b011:  cmd = sdram_pkg::ACTIVE;
        3'b101:  cmd = sdram_pkg::READ;
        3'b100:  cmd = sdram_pkg::WRITE;
        3'b110:  cmd = sdram_pkg::BURST_STOP;
        default: cmd = sdram_pkg::NOP;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd == sdram_pkg::ACTIVE) begin
      row_q  <= a[sdram_pkg::ROW_W-1:0];
      bank_q <= ba;
    end
    if (cmd == sdram_pkg::LOAD_MODE) begin
      mode_reg    <= a;
      mode_loaded <= 1'b1;
    end
  end

  assign bl_code   = mode_reg[sdram_pkg::MR_BL_LSB +: 3];
  assign cas_lat   = mode_reg[sdram_pkg::MR_CL_LSB +: 3];
  assign burst_len = (bl_code <= 3'd3) ? (4'd1 << bl_code[1:0]) : 4'd1;

  assign wr_cmd = (cmd == sdram_pkg::WRITE);
  assign rd_cmd = (cmd == sdram_pkg::READ);
  // a mode load also ends any leftover burst
  assign burst_stop = (cmd == sdram_pkg::BURST_STOP) || (cmd == sdram_pkg::LOAD_MODE);

  assign dq_oe = !(wr_cmd || burst_active);

  sdram_write_path write_path_i (
    .clk          (clk),
    .wr_cmd       (wr_cmd),
    .burst_stop   (burst_stop),
    .col          (a[sdram_pkg::COL_W-1:0]),
    .burst_len    (burst_len),
    .dqm          (dqm),
    .dq_in        (dq_in),
    .old_word     (old_word),
    .mem_we       (mem_we),
    .mem_col      (wr_col),
    .mem_wdata    (mem_wdata),
    .burst_active (burst_active)
  );

  sdram_read_path read_path_i (
    .clk       (clk),
    .rd_cmd    (rd_cmd),
    .col       (a[sdram_pkg::COL_W-1:0]),
    .cas_lat   (cas_lat),
    .mem_rdata (mem_rdata),
    .mem_col   (rd_col),
    .rd_data   (dq_out)
  );

  sdram_bank_array bank_array_i (
    .clk      (clk),
    .bank     (bank_q),
    .row      (row_q),
    .we       (mem_we),
    .wcol     (wr_col),
    .wdata    (mem_wdata),
    .rcol     (rd_col),
    .old_word (old_word),
    .rdata    (mem_rdata)
  );

  a_mode_before_access: assert property (
    @(posedge clk) (rd_cmd || wr_cmd) |-> mode_loaded
  );

endmodule

/* logic/sdram_ctrl.sv */
`timescale 1ns/1ps

module sdram_ctrl (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            host_wr,
  input  logic                            host_rd,
  input  logic [sdram_pkg::HOST_AW-1:0]   addr,
  input  logic [sdram_pkg::HOST_DW-1:0]   wdata,
  input  logic [sdram_pkg::HOST_DW/8-1:0] be,
  output logic                            busy,
  output logic                            rd_valid,
  output logic [sdram_pkg::HOST_DW-1:0]   rdata,
  output logic                            cs,
  output logic                            ras,
  output logic                            cas,
  output logic                            we,
  output logic [sdram_pkg::A_W-1:0]       a,
  output logic [sdram_pkg::BANK_W-1:0]    ba,
  output logic [sdram_pkg::DQ_W/8-1:0]    dqm,
  output logic [sdram_pkg::DQ_W-1:0]      ctrl_dq,
  input  logic [sdram_pkg::DQ_W-1:0]      rd_dq
);

  sdram_pkg::ctrl_state_e state;

  logic                            is_wr;
  logic [2:0]                      lat_cnt;
  logic [sdram_pkg::COL_W-2:0]     cpair_q;
  logic [sdram_pkg::HOST_DW-1:0]   wdata_q;
  logic [sdram_pkg::HOST_DW/8-1:0] be_q;
  logic [sdram_pkg::A_W-1:0]       mode_word;

  // pin levels {cs, ras, cas, we}
  function automatic logic [3:0] pins(input sdram_pkg::sdram_cmd_e cmd);
    case (cmd)
      sdram_pkg::LOAD_MODE:  pins = 4'b0000;
      sdram_pkg::ACTIVE:     pins = 4'b0011;
      sdram_pkg::READ:       pins = 4'b0101;
      sdram_pkg::WRITE:      pins = 4'b0100;
      sdram_pkg::BURST_STOP: pins = 4'b0110;
      default:               pins = 4'b0111;
    endcase
  endfunction

  always_comb begin
    mode_word = '0;
    mode_word[sdram_pkg::MR_BL_LSB +: 3] = sdram_pkg::BL_CODE;
    mode_word[sdram_pkg::MR_CL_LSB +: 3] = 3'(sdram_pkg::CAS_LAT);
  end

  assign busy = (state != sdram_pkg::ST_IDLE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state              <= sdram_pkg::ST_RESET;
      {cs, ras, cas, we} <= pins(sdram_pkg::NOP);
      rd_valid           <= 1'b0;
      is_wr              <= 1'b0;
      lat_cnt            <= '0;
    end else begin
      {cs, ras, cas, we} <= pins(sdram_pkg::NOP);
      rd_valid           <= 1'b0;
      case (state)
        sdram_pkg::ST_RESET: begin
          {cs, ras, cas, we} <= pins(sdram_pkg::LOAD_MODE);
          state              <= sdram_pkg::ST_MODE;
        end
        sdram_pkg::ST_MODE: state <= sdram_pkg::ST_IDLE;
        sdram_pkg::ST_IDLE: begin
          // write wins if both strobes arrive together
          if (host_wr || host_rd) begin
            {cs, ras, cas, we} <= pins(sdram_pkg::ACTIVE);
            is_wr              <= host_wr;
            state              <= sdram_pkg::ST_ACTIVE;
          end
        end
        sdram_pkg::ST_ACTIVE: begin
          lat_cnt <= '0;
          if (is_wr) begin
            {cs, ras, cas, we} <= pins(sdram_pkg::WRITE);
            state              <= sdram_pkg::ST_WRITE;
          end else begin
            {cs, ras, cas, we} <= pins(sdram_pkg::READ);
            state              <= sdram_pkg::ST_READ;
          end
        end
        sdram_pkg::ST_WRITE:    state <= sdram_pkg::ST_WRITE_HI;
        sdram_pkg::ST_WRITE_HI: state <= sdram_pkg::ST_IDLE;
        sdram_pkg::ST_READ: begin
          lat_cnt <= lat_cnt + 3'd1;
          if (lat_cnt == 3'(sdram_pkg::CAS_LAT + 1)) begin
            rd_valid <= 1'b1;
            state    <= sdram_pkg::ST_IDLE;
          end
        end
        default: state <= sdram_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      sdram_pkg::ST_RESET: a <= mode_word;
      sdram_pkg::ST_IDLE: begin
        if (host_wr || host_rd) begin
          ba      <= addr[sdram_pkg::HOST_AW-1 -: sdram_pkg::BANK_W];
          a       <= {{(sdram_pkg::A_W - sdram_pkg::ROW_W){1'b0}},
                      addr[sdram_pkg::COL_W-1 +: sdram_pkg::ROW_W]};
          cpair_q <= addr[sdram_pkg::COL_W-2:0];
          wdata_q <= wdata;
          be_q    <= be;
        end
      end
      sdram_pkg::ST_ACTIVE: begin
        // low half goes to the even column
        a       <= {{(sdram_pkg::A_W - sdram_pkg::COL_W){1'b0}}, cpair_q, 1'b0};
        ctrl_dq <= wdata_q[sdram_pkg::DQ_W-1:0];
        dqm     <= is_wr ? ~be_q[sdram_pkg::DQ_W/8-1:0] : '0;
      end
      sdram_pkg::ST_WRITE: begin
        ctrl_dq <= wdata_q[sdram_pkg::HOST_DW-1 -: sdram_pkg::DQ_W];
        dqm     <= ~be_q[sdram_pkg::HOST_DW/8-1 -: sdram_pkg::DQ_W/8];
      end
      sdram_pkg::ST_READ: begin
        if (lat_cnt == 3'(sdram_pkg::CAS_LAT))
          rdata[sdram_pkg::DQ_W-1:0] <= rd_dq;
        if (lat_cnt == 3'(sdram_pkg::CAS_LAT + 1))
          rdata[sdram_pkg::HOST_DW-1 -: sdram_pkg::DQ_W] <= rd_dq;
      end
      default: ;
    endcase
  end

  // no command on the pins while the host sees the controller idle
  a_idle_pins_nop: assert property (
    @(posedge clk) disable iff (!arst_n)
      !busy |-> ({cs, ras, cas, we} == pins(sdram_pkg::NOP))
  );

endmodule

/* logic/sdram_subsys.sv */
`timescale 1ns/1ps

module sdram_subsys (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            host_wr,
  input  logic                            host_rd,
  input  logic [sdram_pkg::HOST_AW-1:0]   addr,
  input  logic [sdram_pkg::HOST_DW-1:0]   wdata,
  input  logic [sdram_pkg::HOST_DW/8-1:0] be,
  output logic                            busy,
  output logic                            rd_valid,
  output logic [sdram_pkg::HOST_DW-1:0]   rdata
);

  logic                         cs;
  logic                         ras;
  logic                         cas;
  logic                         we;
  logic [sdram_pkg::A_W-1:0]    a;
  logic [sdram_pkg::BANK_W-1:0] ba;
  logic [sdram_pkg::DQ_W/8-1:0] dqm;
  logic [sdram_pkg::DQ_W-1:0]   ctrl_dq;
  logic [sdram_pkg::DQ_W-1:0]   dev_dq;
  logic                         dev_dq_oe;
  logic [sdram_pkg::DQ_W-1:0]   dq_bus;

  // device owns the bus except during write beats
  assign dq_bus = dev_dq_oe ? dev_dq : ctrl_dq;

  sdram_ctrl ctrl_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .host_wr  (host_wr),
    .host_rd  (host_rd),
    .addr     (addr),
    .wdata    (wdata),
    .be       (be),
    .busy     (busy),
    .rd_valid (rd_valid),
    .rdata    (rdata),
    .cs       (cs),
    .ras      (ras),
    .cas      (cas),
    .we       (we),
    .a        (a),
    .ba       (ba),
    .dqm      (dqm),
    .ctrl_dq  (ctrl_dq),
    .rd_dq    (dq_bus)
  );

  sdram_model model_i (
    .clk    (clk),
    .cs     (cs),
    .ras    (ras),
    .cas    (cas),
    .we     (we),
    .a      (a),
    .ba     (ba),
    .dqm    (dqm),
    .dq_in  (ctrl_dq),
    .dq_out (dev_dq),
    .dq_oe  (dev_dq_oe)
  );

endmodule

/* verif/sdram_tb.sv */
`timescale 1ns/1ps

module sdram_tb;

  localparam int TIMEOUT    = 100;
  localparam int RD_LATENCY = 5;

  logic                            clk;
  logic                            arst_n;
  logic                            host_wr;
  logic                            host_rd;
  logic [sdram_pkg::HOST_AW-1:0]   addr;
  logic [sdram_pkg::HOST_DW-1:0]   wdata;
  logic [sdram_pkg::HOST_DW/8-1:0] be;
  logic                            busy;
  logic                            rd_valid;
  logic [sdram_pkg::HOST_DW-1:0]   rdata;

  // expected contents, indexed by host word address
  logic [31:0] shadow [2**sdram_pkg::HOST_AW];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;

  sdram_subsys dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .host_wr  (host_wr),
    .host_rd  (host_rd),
    .addr     (addr),
    .wdata    (wdata),
    .be       (be),
    .busy     (busy),
    .rd_valid (rd_valid),
    .rdata    (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // host address is bank, row, column pair
  function automatic logic [9:0] make_addr(input logic [1:0] bank, input logic [3:0] row,
                                           input logic [3:0] cpair);
    return {bank, row, cpair};
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_idle(input string name);
    int cnt;
    cnt = 0;
    while (busy && cnt < TIMEOUT) begin
      step();
      cnt++;
    end
    if (busy) begin
      errors++;
      $display("ERROR %s: busy still high after %0d cycles", name, TIMEOUT);
    end
  endtask

  task automatic write_word(input string name, input logic [9:0] waddr,
                            input logic [31:0] data, input logic [3:0] mask);
    wait_idle(name);
    addr    = waddr;
    wdata   = data;
    be      = mask;
    host_wr = 1'b1;
    step();
    host_wr = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (mask[i])
        shadow[waddr][8*i +: 8] = data[8*i +: 8];
    end
  endtask

  task automatic read_check(input string name, input logic [9:0] raddr);
    int          cnt;
    logic [31:0] expected;
    wait_idle(name);
    expected = shadow[raddr];
    addr     = raddr;
    host_rd  = 1'b1;
    step();
    host_rd = 1'b0;
    cnt = 0;
    while (!rd_valid && cnt < TIMEOUT) begin
      step();
      cnt++;
    end
    checks++;
    if (!rd_valid) begin
      errors++;
      $display("ERROR %s: no rd_valid within %0d cycles of the read", name, TIMEOUT);
    end else begin
      if (cnt != RD_LATENCY) begin
        errors++;
        $display("MISMATCH %s latency: expected %0d, actual %0d", name, RD_LATENCY, cnt);
      end
      if (rdata !== expected) begin
        errors++;
        $display("MISMATCH %s @%03h: expected %08h, actual %08h", name, raddr, expected, rdata);
      end
      if (busy) begin
        errors++;
        $display("ERROR %s: busy still high while rd_valid is high", name);
      end
      step();
      if (rd_valid) begin
        errors++;
        $display("ERROR %s: rd_valid lasted more than one cycle", name);
      end
    end
  endtask

  task automatic test_reset();
    checks++;
    if (rd_valid !== 1'b0) begin
      errors++;
      $display("MISMATCH reset rd_valid: expected 0, actual %b", rd_valid);
    end
    if (busy !== 1'b1) begin
      errors++;
      $display("MISMATCH reset busy: expected 1, actual %b", busy);
    end
    wait_idle("reset");
    // nothing requested, so nothing should move
    for (int i = 0; i < 20; i++) begin
      if (busy || rd_valid) begin
        errors++;
        $display("ERROR reset: busy or rd_valid rose with no request");
      end
      step();
    end
  endtask

  task automatic test_full_write_read();
    logic [9:0] waddr;
    waddr = make_addr(2'd1, 4'd5, 4'd9);
    write_word("full_write", waddr, next_random(), 4'hf);
    read_check("full_write", waddr);
  endtask

  task automatic test_byte_enables();
    logic [9:0] waddr;
    waddr = make_addr(2'd2, 4'd10, 4'd3);
    write_word("byte_enable", waddr, 32'ha5c3_96e1, 4'hf);
    // every single lane and every pair of lanes
    for (int m = 1; m < 15; m++) begin
      if ($countones(4'(m)) <= 2) begin
        write_word($sformatf("byte_enable_%h", m), waddr, next_random(), 4'(m));
        read_check($sformatf("byte_enable_%h", m), waddr);
      end
    end
  endtask

  task automatic test_random();
    logic [9:0] addrs [20];
    for (int i = 0; i < 20; i++) begin
      addrs[i] = make_addr(2'((i / 4) % 4), 4'(i % 16), 4'(next_random() >> 20));
      write_word("random", addrs[i], next_random(), 4'hf);
    end
    // stride 7 visits all twenty in a new order
    for (int i = 0; i < 20; i++) begin
      read_check("random", addrs[(i * 7) % 20]);
    end
  endtask

  task automatic test_busy_write();
    logic [9:0] keep_addr;
    logic [9:0] other_addr;
    keep_addr  = make_addr(2'd3, 4'd12, 4'd6);
    other_addr = make_addr(2'd0, 4'd3, 4'd11);
    write_word("busy_write", keep_addr, 32'h1357_9bdf, 4'hf);
    write_word("busy_write", other_addr, 32'h2468_ace0, 4'hf);
    checks++;
    if (!busy) begin
      errors++;
      $display("ERROR busy_write: busy low during a write sequence");
    end
    // strobe into a busy controller, must be dropped
    addr    = keep_addr;
    wdata   = 32'hdead_beef;
    be      = 4'hf;
    host_wr = 1'b1;
    step();
    host_wr = 1'b0;
    read_check("busy_write", keep_addr);
    read_check("busy_write", other_addr);
  endtask

  initial begin
    arst_n    = 1'b0;
    host_wr   = 1'b0;
    host_rd   = 1'b0;
    addr      = '0;
    wdata     = '0;
    be        = '0;
    errors    = 0;
    checks    = 0;
    lcg_state = 32'd98819;
    repeat (10) step();
    arst_n = 1'b1;

    test_reset();
    test_full_write_read();
    test_byte_enables();
    test_random();
    test_busy_write();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* project.f */
logic/sdram_pkg.sv
logic/sdram_write_path.sv
logic/sdram_read_path.sv
logic/sdram_bank_array.sv
logic/sdram_model.sv
logic/sdram_ctrl.sv
logic/sdram_subsys.sv
verif/sdram_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SDRAM testbench with Verilator
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert -sv -f project.f --top-module sdram_tb \
  && ./obj_dir/Vsdram_tb | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; } \
  || { echo "test passed"; exit 0; }
